//--- rsc2_enc.f
+incdir+testbench
common/rsc2_pkg.sv
hdl/rsc2_enc_source.sv
ibuf/rsc2_enc_ibuffer.sv
engine/rsc2_enc_permutation.sv
engine/rsc2_enc_engine.sv
hdl/rsc2_enc.sv
testbench/tb_rsc2_enc.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := tb_rsc2_enc
RTL_TOP   := rsc2_enc
FILELIST  := rsc2_enc.f
BUILD     := obj_dir
LOG       := sim.log
PASS_MSG  := Test passed
SOURCES   := $(shell grep -v '^+' $(FILELIST)) testbench/rsc2_enc_model.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

//--- testbench/rsc2_enc_model.svh
`ifndef RSC2_ENC_MODEL_SVH
`define RSC2_ENC_MODEL_SVH

// one expected output symbol
typedef struct packed {
  logic                        sop;
  logic                        eop;
  logic [rsc2_pkg::cTAG_W-1:0] tag;
  rsc2_pkg::duobit_t           dat;
} sym_t;

typedef sym_t sym_q_t [$];

// one trellis step, state {s1, s2, s3}, result {y, w, next state}
function automatic logic [4:0] trellis_step(input logic [2:0] st, input rsc2_pkg::duobit_t ab);
  logic a, b, s1, s2, s3, fb;
  a  = ab[1];
  b  = ab[0];
  s1 = st[2];
  s2 = st[1];
  s3 = st[0];
  fb = a ^ b ^ s1 ^ s3;
  return {fb ^ s2 ^ s3, fb ^ s3, fb, s1 ^ b, s2 ^ b};
endfunction

// whole packet in emission order: d, {y1, y2}, {w1, w2} at rate 1/3
function automatic sym_q_t rsc2_enc_model(input rsc2_pkg::duobit_t dat [rsc2_pkg::cN_MAX],
                                          input int n, input int code, input int ptype,
                                          input logic [rsc2_pkg::cTAG_W-1:0] tag);
  sym_q_t                q;
  rsc2_pkg::perm_entry_t pe;
  logic [2:0]            st1, st2; // natural, permuted
  logic [4:0]            r1, r2;
  rsc2_pkg::duobit_t     d, e;
  int                    off, pj;
  logic                  last, rate13;
  pe     = rsc2_pkg::cPERM_TABLE[ptype];
  rate13 = (code == int'(rsc2_pkg::cCODE_R13));
  st1    = '0;
  st2    = '0;
  for (int j = 0; j < n; j++) begin
    case (j % 4)
      0:       off = 0;
      1:       off = n / 2 + int'(pe.p1);
      2:       off = int'(pe.p2);
      default: off = n / 2 + int'(pe.p3);
    endcase
    pj   = (int'(pe.p0) * j + off + 1) % n;
    last = (j == n - 1);
    d    = dat[j];
    e    = dat[pj];
    if (j % 2 == 1) e = {e[0], e[1]}; // odd j swaps A and B
    r1 = trellis_step(st1, d);
    r2 = trellis_step(st2, e);
    q.push_back(sym_t'({j == 0, 1'b0, tag, d}));
    q.push_back(sym_t'({1'b0, last & ~rate13, tag, r1[4], r2[4]}));
    if (rate13) q.push_back(sym_t'({1'b0, last, tag, r1[3], r2[3]}));
    st1 = r1[2:0];
    st2 = r2[2:0];
  end
  return q;
endfunction

`endif

//--- testbench/tb_rsc2_enc.sv
module tb_rsc2_enc;
  timeunit 1ns;
  timeprecision 100ps;

  `include "rsc2_enc_model.svh"

  // packets under test
  // code 0 is rate 1/3 and code 1 is rate 1/2
  localparam int cNUM_PKT = 10;
  localparam int cPKT_N     [cNUM_PKT] = '{16, 24, 8, 64, 32, 12, 40, 20, 16, 28};
  localparam int cPKT_CODE  [cNUM_PKT] = '{0, 1, 0, 1, 0, 1, 0, 1, 0, 1};
  localparam int cPKT_PTYPE [cNUM_PKT] = '{0, 1, 1, 2, 3, 0, 2, 1, 3, 0};

  logic                           iclk = 1'b0;
  logic                           ireset, ival, isop, ieop, idbsclk;
  rsc2_pkg::duobit_t              idat;
  logic [rsc2_pkg::cTAG_W-1:0]    itag;
  logic [rsc2_pkg::cCODE_W-1:0]   icode;
  logic [rsc2_pkg::cPTYPE_W-1:0]  iptype;
  logic                           obusy, ordy, osop, oeop, oeof, oval;
  rsc2_pkg::duobit_t              odat;
  logic [rsc2_pkg::cTAG_W-1:0]    otag;
  sym_q_t                         exp_q;    // scoreboard
  int                             errors;
  int                             dbs_mode; // strobe pattern (0 high, 1 random gaps, 2 low)

  rsc2_enc i_dut (
    .iclk (iclk), .ireset (ireset), .ival (ival), .isop (isop), .ieop (ieop),
    .idat (idat), .itag (itag), .icode (icode), .iptype (iptype), .idbsclk (idbsclk),
    .obusy (obusy), .ordy (ordy), .osop (osop), .oeop (oeop), .oeof (oeof),
    .oval (oval), .odat (odat), .otag (otag)
  );

  always #5 iclk = ~iclk;

  // symbol strobe driven 1 ns after the edge like the other inputs
  always @(posedge iclk) begin
    #1;
    case (dbs_mode)
      0:       idbsclk = 1'b1;
      1:       idbsclk = ($urandom % 3) != 0;
      default: idbsclk = 1'b0;
    endcase
  end

  task automatic compare_field(input string name, input logic [7:0] expv, input logic [7:0] got);
    if (expv !== got) begin
      $display("Error at %0t: %s expected 'h%0h, got 'h%0h", $time, name, expv, got);
      errors++;
    end
  endtask

  // --------------------
  // output compare
  // --------------------

  always @(negedge iclk) begin
    sym_t exp;
    if (!ireset && oval) begin
      if (!idbsclk) begin
        $display("Error at %0t: oval is high while idbsclk is low", $time);
        errors++;
      end
      if (exp_q.size() == 0) begin
        $display("output symbol at %0t arrived with nothing left to expect", $time);
        errors++;
      end else begin
        exp = exp_q.pop_front();
        compare_field("odat", 8'(exp.dat), 8'(odat));
        compare_field("otag", exp.tag, otag);
        compare_field("osop", 8'(exp.sop), 8'(osop));
        compare_field("oeop", 8'(exp.eop), 8'(oeop));
        compare_field("oeof", 8'(exp.eop), 8'(oeof)); // same as oeop here
      end
    end
  end

  // entered and left 1 ns after a rising edge
  task automatic send_packet(input int idx);
    rsc2_pkg::duobit_t dat [rsc2_pkg::cN_MAX];
    sym_q_t            syms;
    logic [7:0]        tag;
    int                n;
    n   = cPKT_N[idx];
    tag = 8'($urandom);
    for (int i = 0; i < rsc2_pkg::cN_MAX; i++) begin
      dat[i] = (i < n) ? 2'($urandom) : 2'b00;
    end
    syms = rsc2_enc_model(dat, n, cPKT_CODE[idx], cPKT_PTYPE[idx], tag);
    foreach (syms[k]) exp_q.push_back(syms[k]);
    while (!ordy) begin // isop only when ready
      @(posedge iclk);
      #1;
    end
    for (int i = 0; i < n; i++) begin
      ival   = 1'b1;
      isop   = (i == 0);
      ieop   = (i == n - 1);
      idat   = dat[i];
      // context is sampled with ieop only so earlier beats carry junk
      itag   = ieop ? tag : 8'($urandom);
      icode  = ieop ? 4'(cPKT_CODE[idx]) : 4'($urandom);
      iptype = ieop ? 2'(cPKT_PTYPE[idx]) : 2'($urandom);
      @(posedge iclk);
      #1;
    end
    ival = 1'b0;
    isop = 1'b0;
    ieop = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge iclk);
      #1;
    end
    repeat (2) begin // let release land
      @(posedge iclk);
      #1;
    end
  endtask

  // run bound of 20 cycles per expected symbol plus margin
  initial begin
    int total;
    total = 0;
    for (int i = 0; i < cNUM_PKT; i++) begin
      total += cPKT_N[i] * ((cPKT_CODE[i] == 0) ? 3 : 2);
    end
    repeat (total * 20 + 2000) @(posedge iclk);
    $display("timeout: %0d expected symbols still missing", exp_q.size());
    $display("Test failed");
    $finish;
  end

  // --------------------
  // stimulus
  // --------------------

  initial begin
    ireset   = 1'b1;
    ival     = 1'b0;
    isop     = 1'b0;
    ieop     = 1'b0;
    idat     = '0;
    itag     = '0;
    icode    = '0;
    iptype   = '0;
    idbsclk  = 1'b1;
    dbs_mode = 0;
    errors   = 0;
    void'($urandom(32'h3a0a));
    repeat (5) @(posedge iclk);
    #1 ireset = 1'b0;
    @(negedge iclk); // idle status after reset
    compare_field("oval", 8'd0, 8'(oval));
    compare_field("osop", 8'd0, 8'(osop));
    compare_field("oeop", 8'd0, 8'(oeop));
    compare_field("oeof", 8'd0, 8'(oeof));
    compare_field("obusy", 8'd0, 8'(obusy));
    compare_field("ordy", 8'd1, 8'(ordy));
    @(posedge iclk);
    #1;
    send_packet(0); // rate 1/3 with 16 duobits
    wait_drained();
    send_packet(1); // rate 1/2
    wait_drained();
    for (int i = 2; i < 6; i++) send_packet(i); // mixed packets back to back
    wait_drained();
    dbs_mode = 1; // strobe gaps
    send_packet(6);
    send_packet(7);
    wait_drained();
    dbs_mode = 2; // stall output to fill both banks
    send_packet(8);
    send_packet(9);
    repeat (4) @(negedge iclk);
    compare_field("obusy", 8'd1, 8'(obusy));
    compare_field("ordy", 8'd0, 8'(ordy));
    dbs_mode = 0;
    wait_drained();
    @(negedge iclk);
    compare_field("obusy", 8'd0, 8'(obusy));
    compare_field("ordy", 8'd1, 8'(ordy));
    if (exp_q.size() != 0) begin
      $display("%0d expected symbols never came out", exp_q.size());
      errors++;
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- hdl/rsc2_enc.sv
module rsc2_enc (
  input  logic                           iclk,
  input  logic                           ireset,
  input  logic                           ival,
  input  logic                           isop,
  input  logic                           ieop,
  input  rsc2_pkg::duobit_t              idat,
  input  logic [rsc2_pkg::cTAG_W-1:0]    itag,
  input  logic [rsc2_pkg::cCODE_W-1:0]   icode,  // 0 - 1/3, 1 - 1/2
  input  logic [rsc2_pkg::cPTYPE_W-1:0]  iptype,
  input  logic                           idbsclk, // output symbol strobe
  output logic                           obusy,
  output logic                           ordy,
  output logic                           osop,
  output logic                           oeop,
  output logic                           oeof,
  output logic                           oval,
  output rsc2_pkg::duobit_t              odat,
  output logic [rsc2_pkg::cTAG_W-1:0]    otag
);

  //--------------------
  // write side
  //--------------------

  logic                          src_write;
  logic                          src_done;
  logic [rsc2_pkg::cADDR_W-1:0]  src_waddr;
  rsc2_pkg::duobit_t             src_wdat;
  logic                          src_wbank;
  rsc2_pkg::frame_ctx_t          src_wctx;

  //--------------------
  // read side
  //--------------------

  logic [1:0]                    buf_full;   // per bank
  rsc2_pkg::duobit_t             buf_rdat0;  // natural order
  rsc2_pkg::duobit_t             buf_rdat1;  // permuted order
  rsc2_pkg::frame_ctx_t          buf_rctx;
  logic                          eng_rbank;
  logic [rsc2_pkg::cADDR_W-1:0]  eng_raddr0;
  logic [rsc2_pkg::cADDR_W-1:0]  eng_raddr1;
  logic                          eng_rrelease;

  rsc2_enc_source source (
    .iclk   (iclk),      .ireset (ireset),
    .ival   (ival),      .isop   (isop),      .ieop   (ieop),
    .idat   (idat),      .itag   (itag),      .icode  (icode),   .iptype (iptype),
    .full   (buf_full),
    .write  (src_write), .done   (src_done),  .waddr  (src_waddr),
    .wdat   (src_wdat),  .wbank  (src_wbank), .wctx   (src_wctx),
    .obusy  (obusy),     .ordy   (ordy)
  );

  rsc2_enc_ibuffer ibuf (
    .iclk     (iclk),         .ireset (ireset),
    .write    (src_write),    .waddr  (src_waddr),  .wdat   (src_wdat),
    .wbank    (src_wbank),    .done   (src_done),   .wctx   (src_wctx),
    .rbank    (eng_rbank),    .raddr0 (eng_raddr0), .raddr1 (eng_raddr1),
    .rrelease (eng_rrelease),
    .rdat0    (buf_rdat0),    .rdat1  (buf_rdat1),  .rctx   (buf_rctx),
    .full     (buf_full)
  );

  rsc2_enc_engine engine (
    .iclk     (iclk),         .ireset (ireset),
    .full     (buf_full),     .rdat0  (buf_rdat0),  .rdat1  (buf_rdat1),
    .rctx     (buf_rctx),     .idbsclk (idbsclk),
    .rbank    (eng_rbank),    .raddr0 (eng_raddr0), .raddr1 (eng_raddr1),
    .rrelease (eng_rrelease),
    .osop     (osop),         .oeop   (oeop),       .oeof   (oeof),
    .oval     (oval),         .odat   (odat),       .otag   (otag)
  );

endmodule

//--- engine/rsc2_enc_engine.sv
module rsc2_enc_engine (
  input  logic                          iclk,
  input  logic                          ireset,
  input  logic [1:0]                    full,
  input  rsc2_pkg::duobit_t             rdat0,
  input  rsc2_pkg::duobit_t             rdat1,
  input  rsc2_pkg::frame_ctx_t          rctx,
  input  logic                          idbsclk,
  output logic                          rbank,
  output logic [rsc2_pkg::cADDR_W-1:0]  raddr0,
  output logic [rsc2_pkg::cADDR_W-1:0]  raddr1,
  output logic                          rrelease,
  output logic                          osop,
  output logic                          oeop,
  output logic                          oeof,
  output logic                          oval,
  output rsc2_pkg::duobit_t             odat,
  output logic [rsc2_pkg::cTAG_W-1:0]   otag
);

  typedef enum logic [2:0] {
    st_idle,   // wait for expected bank
    st_fetch,  // addresses out, data next cycle
    st_sys,    // systematic pair
    st_par_y,  // {Y1, Y2}
    st_par_w   // {W1, W2}, rate 1/3 only
  } state_t;

  state_t                        state;
  rsc2_pkg::frame_ctx_t          ctx_r;   // held for the whole packet
  logic [2:0]                    s_nat;   // encoder 1 state
  logic [2:0]                    s_perm;  // encoder 2 state
  logic                          start;
  logic                          step;
  logic                          swap;
  logic [rsc2_pkg::cADDR_W-1:0]  addr;
  logic [rsc2_pkg::cADDR_W-1:0]  paddr;
  rsc2_pkg::duobit_t             d;
  rsc2_pkg::duobit_t             e;
  logic [1:0]                    par1;    // {Y1, W1}
  logic [1:0]                    par2;    // {Y2, W2}
  logic                          rate13;
  logic                          last_step;
  logic                          emit;
  logic                          sym_end;

  rsc2_enc_permutation perm (
    .iclk  (iclk),       .ireset (ireset),
    .start (start),      .step   (step),
    .n     (rctx.n),     .ptype  (rctx.ptype),
    .addr  (addr),       .paddr  (paddr),     .swap (swap)
  );

  assign start  = (state == st_idle) & full[rbank];
  assign raddr0 = addr;
  assign raddr1 = paddr;

  //--------------------
  // datapath
  //--------------------

  assign d    = rdat0;
  assign e    = swap ? {rdat1[0], rdat1[1]} : rdat1; // A/B swap on odd j
  assign par1 = rsc2_pkg::rsc_parity(s_nat, d);
  assign par2 = rsc2_pkg::rsc_parity(s_perm, e);

  assign rate13    = (ctx_r.code == rsc2_pkg::cCODE_R13);
  assign last_step = (int'(addr) + 1 == int'(ctx_r.n));
  assign emit      = idbsclk & (state inside {st_sys, st_par_y, st_par_w});
  assign sym_end   = emit & ((state == st_par_w) | (state == st_par_y & ~rate13));
  assign step      = sym_end & ~last_step;
  assign rrelease  = sym_end & last_step;

  always_comb begin
    case (state)
      st_par_y: odat = {par1[1], par2[1]};
      st_par_w: odat = {par1[0], par2[0]};
      default:  odat = d;
    endcase
  end

  assign oval = emit;
  assign osop = emit & (state == st_sys) & (addr == '0); // first symbol
  assign oeop = rrelease;
  assign oeof = rrelease;
  assign otag = ctx_r.tag;

  //--------------------
  // sequencer
  //--------------------

  always_ff @(posedge iclk) begin
    if (ireset) begin
      state <= st_idle;
      rbank <= 1'b0;
    end else begin
      case (state)
        st_idle:  if (start) state <= st_fetch;
        st_fetch: state <= st_sys;
        st_sys:   if (idbsclk) state <= st_par_y;
        st_par_y: if (idbsclk && rate13) state <= st_par_w;
        default:  state <= state;
      endcase
      if (sym_end) begin
        state <= last_step ? st_idle : st_fetch;
      end
      if (rrelease) begin
        rbank <= ~rbank; // same order as the source
      end
    end
  end

  // both encoders start from zero, no termination
  always_ff @(posedge iclk) begin
    if (start) begin
      ctx_r  <= rctx;
      s_nat  <= '0;
      s_perm <= '0;
    end else if (sym_end) begin
      s_nat  <= rsc2_pkg::rsc_next(s_nat, d);
      s_perm <= rsc2_pkg::rsc_next(s_perm, e);
    end
  end

endmodule

//--- engine/rsc2_enc_permutation.sv
module rsc2_enc_permutation (
  input  logic                           iclk,
  input  logic                           ireset,
  input  logic                           start,
  input  logic                           step,
  input  logic [rsc2_pkg::cLEN_W-1:0]    n,
  input  logic [rsc2_pkg::cPTYPE_W-1:0]  ptype,
  output logic [rsc2_pkg::cADDR_W-1:0]   addr,   // natural, j
  output logic [rsc2_pkg::cADDR_W-1:0]   paddr,  // permuted
  output logic                           swap
);

  // v mod m by repeated subtraction, enough for v <= 8*m
  function automatic logic [rsc2_pkg::cADDR_W-1:0] mod_reduce(input int v, input int m);
    int r;
    r = v;
    for (int i = 0; i < 8; i++) begin
      if (r >= m) begin
        r = r - m;
      end
    end
    return r[rsc2_pkg::cADDR_W-1:0];
  endfunction

  rsc2_pkg::perm_entry_t        pe;
  int                           half;      // n/2
  logic [rsc2_pkg::cADDR_W-1:0] q_in [4];  // (q + 1) mod n, from inputs
  logic [rsc2_pkg::cADDR_W-1:0] qoff [4];  // same, latched at start
  logic [rsc2_pkg::cADDR_W-1:0] p0_mod;
  logic [rsc2_pkg::cLEN_W-1:0]  n_r;
  logic [rsc2_pkg::cADDR_W-1:0] j_cnt;
  logic [rsc2_pkg::cADDR_W-1:0] j_nxt;
  logic [rsc2_pkg::cADDR_W-1:0] acc;       // p0*j mod n
  logic [rsc2_pkg::cADDR_W-1:0] acc_nxt;

  assign pe      = rsc2_pkg::cPERM_TABLE[ptype];
  assign half    = int'(n) / 2;
  assign q_in[0] = mod_reduce(1, int'(n));
  assign q_in[1] = mod_reduce(half + int'(pe.p1) + 1, int'(n));
  assign q_in[2] = mod_reduce(int'(pe.p2) + 1, int'(n));
  assign q_in[3] = mod_reduce(half + int'(pe.p3) + 1, int'(n));

  assign j_nxt   = j_cnt + 1'b1;
  assign acc_nxt = mod_reduce(int'(acc) + int'(p0_mod), int'(n_r)); // no multiplier

  // per packet constants
  always_ff @(posedge iclk) begin
    if (start) begin
      p0_mod <= mod_reduce(int'(pe.p0), int'(n));
      qoff   <= q_in;
      n_r    <= n;
    end
  end

  always_ff @(posedge iclk) begin
    if (ireset) begin
      j_cnt <= '0;
      acc   <= '0;
      paddr <= '0;
    end else if (start) begin
      j_cnt <= '0;
      acc   <= '0;
      paddr <= q_in[0];
    end else if (step) begin
      j_cnt <= j_nxt;
      acc   <= acc_nxt;
      paddr <= mod_reduce(int'(acc_nxt) + int'(qoff[j_nxt[1:0]]), int'(n_r));
    end
  end

  assign addr = j_cnt;
  assign swap = j_cnt[0]; // odd j

endmodule

//--- ibuf/rsc2_enc_ibuffer.sv
module rsc2_enc_ibuffer (
  input  logic                          iclk,
  input  logic                          ireset,
  // write side
  input  logic                          write,
  input  logic [rsc2_pkg::cADDR_W-1:0]  waddr,
  input  rsc2_pkg::duobit_t             wdat,
  input  logic                          wbank,
  input  logic                          done,
  input  rsc2_pkg::frame_ctx_t          wctx,
  // read side
  input  logic                          rbank,
  input  logic [rsc2_pkg::cADDR_W-1:0]  raddr0,
  input  logic [rsc2_pkg::cADDR_W-1:0]  raddr1,
  input  logic                          rrelease,
  output rsc2_pkg::duobit_t             rdat0,
  output rsc2_pkg::duobit_t             rdat1,
  output rsc2_pkg::frame_ctx_t          rctx,
  // status
  output logic [1:0]                    full
);

  //--------------------
  // storage
  //--------------------

  // both banks in one array, bank number is the address msb
  rsc2_pkg::duobit_t    mem [2*rsc2_pkg::cN_MAX];
  rsc2_pkg::frame_ctx_t ctx [2]; // tag per bank

  always_ff @(posedge iclk) begin
    if (write) begin
      mem[{wbank, waddr}] <= wdat;
    end
    if (done) begin
      ctx[wbank] <= wctx; // latched with the last duobit
    end
  end

  // two registered read ports, natural and permuted
  always_ff @(posedge iclk) begin
    rdat0 <= mem[{rbank, raddr0}];
    rdat1 <= mem[{rbank, raddr1}];
  end

  assign rctx = ctx[rbank]; // stable while the bank is full

  //--------------------
  // full flags
  //--------------------

  always_ff @(posedge iclk) begin
    if (ireset) begin
      full <= '0;
    end else begin
      for (int b = 0; b < 2; b++) begin
        if (done && wbank == b[0]) begin
          full[b] <= 1'b1;
        end else if (rrelease && rbank == b[0]) begin
          full[b] <= 1'b0; // engine is done with it
        end
      end
    end
  end

endmodule

//--- hdl/rsc2_enc_source.sv
module rsc2_enc_source (
  input  logic                           iclk,
  input  logic                           ireset,
  input  logic                           ival,
  input  logic                           isop,
  input  logic                           ieop,
  input  rsc2_pkg::duobit_t              idat,
  input  logic [rsc2_pkg::cTAG_W-1:0]    itag,
  input  logic [rsc2_pkg::cCODE_W-1:0]   icode,
  input  logic [rsc2_pkg::cPTYPE_W-1:0]  iptype,
  input  logic [1:0]                     full,   // bank full flags
  output logic                           write,
  output logic                           done,   // last duobit of packet
  output logic [rsc2_pkg::cADDR_W-1:0]   waddr,
  output rsc2_pkg::duobit_t              wdat,
  output logic                           wbank,
  output rsc2_pkg::frame_ctx_t           wctx,
  output logic                           obusy,
  output logic                           ordy
);

  logic [rsc2_pkg::cADDR_W-1:0] cnt;    // next write address
  logic                         bank;   // bank being filled
  logic                         in_pkt; // between isop and ieop
  int                           wlen;

  // isop restarts addressing
  // stray ival outside a packet is dropped
  assign write = ival & (isop | in_pkt);
  assign done  = write & ieop;
  assign waddr = isop ? '0 : cnt;
  assign wdat  = idat;
  assign wbank = bank;
  assign wlen  = int'(waddr) + 1;

  // context only matters on done
  always_comb begin
    wctx.code  = icode;
    wctx.ptype = iptype;
    wctx.n     = wlen[rsc2_pkg::cLEN_W-1:0]; // count so far incl. this duobit
    wctx.tag   = itag;
  end

  always_ff @(posedge iclk) begin
    if (ireset) begin
      cnt    <= '0;
      bank   <= 1'b0;
      in_pkt <= 1'b0;
    end else if (write) begin
      cnt    <= waddr + 1'b1;
      in_pkt <= ~ieop;
      if (ieop) begin
        bank <= ~bank; // ping-pong
      end
    end
  end

  //--------------------
  // flow status
  //--------------------

  assign obusy = full[bank];          // engine still owns the next bank
  assign ordy  = ~obusy & ~in_pkt;

endmodule

//--- common/rsc2_pkg.sv
package rsc2_pkg;

  //--------------------
  // sizes
  //--------------------

  localparam int cN_MAX   = 64; // duobits per packet, upper bound
  localparam int cADDR_W  = 6;  // duobit address
  localparam int cLEN_W   = 7;  // packet length, holds cN_MAX itself
  localparam int cTAG_W   = 8;
  localparam int cCODE_W  = 4;
  localparam int cPTYPE_W = 2;

  // coderate codes, the rest of the range is not supported
  localparam logic [cCODE_W-1:0] cCODE_R13 = 4'd0; // 1/3
  localparam logic [cCODE_W-1:0] cCODE_R12 = 4'd1; // 1/2

  //--------------------
  // types
  //--------------------

  typedef logic [1:0] duobit_t; // {A, B}

  // per packet context, stored next to the data in the input buffer
  typedef struct packed {
    logic [cCODE_W-1:0]  code;
    logic [cPTYPE_W-1:0] ptype;
    logic [cLEN_W-1:0]   n;   // duobits in packet
    logic [cTAG_W-1:0]   tag;
  } frame_ctx_t;

  typedef struct packed {
    logic [cADDR_W-1:0] p0; // odd, coprime with every legal n
    logic [cADDR_W-1:0] p1;
    logic [cADDR_W-1:0] p2;
    logic [cADDR_W-1:0] p3;
  } perm_entry_t;

  // indexed by ptype
  localparam perm_entry_t cPERM_TABLE [4] = '{
    '{p0: 6'd29, p1: 6'd2,  p2: 6'd10, p3: 6'd6},
    '{p0: 6'd31, p1: 6'd4,  p2: 6'd8,  p3: 6'd14},
    '{p0: 6'd37, p1: 6'd12, p2: 6'd2,  p3: 6'd18},
    '{p0: 6'd43, p1: 6'd6,  p2: 6'd20, p3: 6'd24}
  };

  //--------------------
  // rsc step, state is {s1, s2, s3}
  //--------------------

  function automatic logic [2:0] rsc_next(input logic [2:0] s, input duobit_t d);
    logic f;
    f = d[1] ^ d[0] ^ s[2] ^ s[0]; // feedback
    return {f, s[2] ^ d[0], s[1] ^ d[0]};
  endfunction

  // returns {Y, W}
  function automatic logic [1:0] rsc_parity(input logic [2:0] s, input duobit_t d);
    logic f;
    f = d[1] ^ d[0] ^ s[2] ^ s[0];
    return {f ^ s[1] ^ s[0], f ^ s[0]};
  endfunction

endpackage
